// ==== Bender.yml ====
package:
  name: mem_subsys

sources:
  - axi_lite_pkg.sv
  - soc_map_pkg.sv
  - arbiter.sv
  - xbar.sv
  - axi_lite_ram.sv
  - axi_lite_timer.sv
  - mem_subsys.sv
  - target: test
    files:
      - mem_subsys_tb.sv

// ==== arbiter.sv ====
module arbiter (
    input  logic                       clk,
    input  logic                       rst_n,
    input  axi_lite_pkg::rd_req_t      fetch_req,
    output axi_lite_pkg::rd_resp_t     fetch_resp,
    input  axi_lite_pkg::req_t         lsu_req,
    output axi_lite_pkg::resp_t_bundle lsu_resp,
    output axi_lite_pkg::req_t         bus_req,
    input  axi_lite_pkg::resp_t_bundle bus_resp
);

    soc_map_pkg::master_t grant;
    soc_map_pkg::master_t winner;
    logic busy;
    logic pass;
    logic addr_hs;
    logic resp_hs;

    // lsu first, then fetch, otherwise keep the current grant
    always_comb begin
        if (lsu_req.ar_valid || lsu_req.aw_valid) begin
            winner = soc_map_pkg::MASTER_LSU;
        end else if (fetch_req.ar_valid) begin
            winner = soc_map_pkg::MASTER_FETCH;
        end else begin
            winner = grant;
        end
    end

    // address valids reach the bus only once the grant matches the winner
    assign pass = !busy && (winner == grant);

    assign addr_hs = (bus_req.ar_valid && bus_resp.ar_ready) ||
                     (bus_req.aw_valid && bus_resp.aw_ready);
    assign resp_hs = (bus_resp.r_valid && bus_req.r_ready) ||
                     (bus_resp.b_valid && bus_req.b_ready);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grant <= soc_map_pkg::MASTER_FETCH;
            busy  <= 1'b0;
        end else begin
            if (!busy) begin
                grant <= winner;
            end
            if (addr_hs) begin
                busy <= 1'b1;
            end else if (resp_hs) begin
                busy <= 1'b0;
            end
        end
    end

    always_comb begin
        bus_req    = '0;
        fetch_resp = '0;
        lsu_resp   = '0;
        if (grant == soc_map_pkg::MASTER_FETCH) begin
            bus_req.ar          = fetch_req.ar;
            bus_req.ar_valid    = fetch_req.ar_valid && pass;
            bus_req.r_ready     = fetch_req.r_ready;
            fetch_resp.ar_ready = bus_resp.ar_ready && bus_req.ar_valid;
            fetch_resp.r        = bus_resp.r;
            fetch_resp.r_valid  = bus_resp.r_valid;
        end else begin
            bus_req           = lsu_req;
            bus_req.ar_valid  = lsu_req.ar_valid && pass;
            bus_req.aw_valid  = lsu_req.aw_valid && pass;
            bus_req.w_valid   = lsu_req.w_valid && pass;
            lsu_resp          = bus_resp;
            // readies only for a request actually on the bus
            lsu_resp.ar_ready = bus_resp.ar_ready && bus_req.ar_valid;
            lsu_resp.aw_ready = bus_resp.aw_ready && bus_req.aw_valid;
            lsu_resp.w_ready  = bus_resp.w_ready && bus_req.w_valid;
        end
    end

    // a transaction keeps its master until the response completes
    a_grant_held: assert property (@(posedge clk) disable iff (!rst_n)
        (addr_hs || busy) |=> $stable(grant));

    // responses only come back for the transaction in flight
    a_resp_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
        (bus_resp.r_valid || bus_resp.b_valid) |-> busy);

endmodule

// ==== axi_lite_pkg.sv ====
package axi_lite_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

    // channel payloads
    typedef struct packed {
        addr_t addr;
    } ar_chan_t;

    typedef struct packed {
        data_t data;
        resp_t resp;
    } r_chan_t;

    typedef struct packed {
        addr_t addr;
    } aw_chan_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } w_chan_t;

    typedef struct packed {
        resp_t resp;
    } b_chan_t;

    // read-only master bundles
    typedef struct packed {
        ar_chan_t ar;
        logic     ar_valid;
        logic     r_ready;
    } rd_req_t;

    typedef struct packed {
        logic     ar_ready;
        r_chan_t  r;
        logic     r_valid;
    } rd_resp_t;

    // full read/write bundles
    typedef struct packed {
        ar_chan_t ar;
        logic     ar_valid;
        logic     r_ready;
        aw_chan_t aw;
        logic     aw_valid;
        w_chan_t  w;
        logic     w_valid;
        logic     b_ready;
    } req_t;

    typedef struct packed {
        logic     ar_ready;
        r_chan_t  r;
        logic     r_valid;
        logic     aw_ready;
        logic     w_ready;
        b_chan_t  b;
        logic     b_valid;
    } resp_t_bundle;

endpackage

// ==== axi_lite_ram.sv ====
module axi_lite_ram (
    input  logic                       clk,
    input  logic                       rst_n,
    input  axi_lite_pkg::req_t         req,
    output axi_lite_pkg::resp_t_bundle resp
);

    localparam int IDX_W = $clog2(soc_map_pkg::RAM_WORDS);

    axi_lite_pkg::data_t mem [soc_map_pkg::RAM_WORDS];
    axi_lite_pkg::data_t r_data_q;
    logic             r_valid_q;
    logic             b_valid_q;
    logic             idle;
    logic             wr_ready;
    logic             rd_hs;
    logic             wr_hs;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    assign idle   = !r_valid_q && !b_valid_q;
    assign rd_idx = req.ar.addr[IDX_W+1:2];
    assign wr_idx = req.aw.addr[IDX_W+1:2];

    // aw and w accepted together, reads first
    assign wr_ready = idle && req.aw_valid && req.w_valid && !req.ar_valid;

    assign rd_hs = req.ar_valid && idle;
    assign wr_hs = wr_ready;

    always_comb begin
        resp          = '0;
        resp.ar_ready = idle;
        resp.aw_ready = wr_ready;
        resp.w_ready  = wr_ready;
        resp.r.data   = r_data_q;
        resp.r.resp   = axi_lite_pkg::RESP_OKAY;
        resp.r_valid  = r_valid_q;
        resp.b.resp   = axi_lite_pkg::RESP_OKAY;
        resp.b_valid  = b_valid_q;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            r_valid_q <= 1'b0;
            b_valid_q <= 1'b0;
        end else begin
            if (rd_hs) begin
                r_valid_q <= 1'b1;
            end else if (req.r_ready) begin
                r_valid_q <= 1'b0;
            end
            if (wr_hs) begin
                b_valid_q <= 1'b1;
            end else if (req.b_ready) begin
                b_valid_q <= 1'b0;
            end
        end
    end

    // storage and read data
    always_ff @(posedge clk) begin
        if (rd_hs) begin
            r_data_q <= mem[rd_idx];
        end
        if (wr_hs) begin
            for (int i = 0; i < $bits(axi_lite_pkg::strb_t); i++) begin
                if (req.w.strb[i]) begin
                    mem[wr_idx][8*i +: 8] <= req.w.data[8*i +: 8];
                end
            end
        end
    end

    a_one_resp: assert property (@(posedge clk) disable iff (!rst_n)
        !(resp.r_valid && resp.b_valid));

endmodule

// ==== axi_lite_timer.sv ====
module axi_lite_timer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  axi_lite_pkg::req_t         req,
    output axi_lite_pkg::resp_t_bundle resp
);

    logic [63:0]         mtime_q;
    logic [63:0]         mtime_next;
    axi_lite_pkg::data_t rd_data;
    axi_lite_pkg::data_t r_data_q;
    logic                r_valid_q;
    logic                b_valid_q;
    logic                idle;
    logic                wr_ready;
    logic                rd_hs;

    assign idle     = !r_valid_q && !b_valid_q;
    assign wr_ready = idle && req.aw_valid && req.w_valid && !req.ar_valid;
    assign rd_hs    = req.ar_valid && idle;

    always_comb begin
        resp          = '0;
        resp.ar_ready = idle;
        resp.aw_ready = wr_ready;
        resp.w_ready  = wr_ready;
        resp.r.data   = r_data_q;
        resp.r.resp   = axi_lite_pkg::RESP_OKAY;
        resp.r_valid  = r_valid_q;
        resp.b.resp   = axi_lite_pkg::RESP_OKAY;
        resp.b_valid  = b_valid_q;
    end

    // count every cycle, a write overrides the strobed bytes of one half
    always_comb begin
        mtime_next = mtime_q + 64'd1;
        if (wr_ready) begin
            for (int i = 0; i < $bits(axi_lite_pkg::strb_t); i++) begin
                if (req.w.strb[i] && req.aw.addr[3:0] == soc_map_pkg::MTIME_LO_OFF) begin
                    mtime_next[8*i +: 8] = req.w.data[8*i +: 8];
                end
                if (req.w.strb[i] && req.aw.addr[3:0] == soc_map_pkg::MTIME_HI_OFF) begin
                    mtime_next[32 + 8*i +: 8] = req.w.data[8*i +: 8];
                end
            end
        end
    end

    always_comb begin
        case (req.ar.addr[3:0])
            soc_map_pkg::MTIME_LO_OFF: rd_data = mtime_q[31:0];
            soc_map_pkg::MTIME_HI_OFF: rd_data = mtime_q[63:32];
            default:                   rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtime_q   <= '0;
            r_valid_q <= 1'b0;
            b_valid_q <= 1'b0;
        end else begin
            mtime_q <= mtime_next;
            if (rd_hs) begin
                r_valid_q <= 1'b1;
            end else if (req.r_ready) begin
                r_valid_q <= 1'b0;
            end
            if (wr_ready) begin
                b_valid_q <= 1'b1;
            end else if (req.b_ready) begin
                b_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hs) begin
            r_data_q <= rd_data;
        end
    end

endmodule

// ==== mem_subsys.f ====
axi_lite_pkg.sv
soc_map_pkg.sv
arbiter.sv
xbar.sv
axi_lite_ram.sv
axi_lite_timer.sv
mem_subsys.sv
mem_subsys_tb.sv

// ==== mem_subsys.sv ====
module mem_subsys (
    input  logic                       clk,
    input  logic                       rst_n,
    input  axi_lite_pkg::rd_req_t      fetch_req,
    output axi_lite_pkg::rd_resp_t     fetch_resp,
    input  axi_lite_pkg::req_t         lsu_req,
    output axi_lite_pkg::resp_t_bundle lsu_resp
);

    axi_lite_pkg::req_t         bus_req;
    axi_lite_pkg::resp_t_bundle bus_resp;
    axi_lite_pkg::req_t         ram_req;
    axi_lite_pkg::resp_t_bundle ram_resp;
    axi_lite_pkg::req_t         timer_req;
    axi_lite_pkg::resp_t_bundle timer_resp;

    arbiter arbiter0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_req  (fetch_req),
        .fetch_resp (fetch_resp),
        .lsu_req    (lsu_req),
        .lsu_resp   (lsu_resp),
        .bus_req    (bus_req),
        .bus_resp   (bus_resp)
    );

    xbar xbar0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus_req    (bus_req),
        .bus_resp   (bus_resp),
        .ram_req    (ram_req),
        .ram_resp   (ram_resp),
        .timer_req  (timer_req),
        .timer_resp (timer_resp)
    );

    axi_lite_ram ram0 (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (ram_req),
        .resp  (ram_resp)
    );

    axi_lite_timer timer0 (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (timer_req),
        .resp  (timer_resp)
    );

endmodule

// ==== mem_subsys_tb.sv ====
module mem_subsys_tb;

    localparam int          RESET_CYCLES = 10;
    localparam int          N_FETCH      = 200;
    localparam int          N_LSU        = 300;
    // init writes, fetch reads, up to two per lsu op, directed tests
    localparam int          TOTAL_TXN    = soc_map_pkg::RAM_WORDS + N_FETCH + 2 * N_LSU + 8;
    localparam int          TXN_CYCLES   = 64;
    localparam logic [31:0] SEED         = 32'h55957345;

    // response channels watched by wait_response
    localparam int CH_FETCH_R = 0;
    localparam int CH_LSU_R   = 1;
    localparam int CH_LSU_B   = 2;

    logic                       clk;
    logic                       rst_n;
    axi_lite_pkg::rd_req_t      fetch_req;
    axi_lite_pkg::rd_resp_t     fetch_resp;
    axi_lite_pkg::req_t         lsu_req;
    axi_lite_pkg::resp_t_bundle lsu_resp;

    // reference copy of the ram contents
    axi_lite_pkg::data_t model [soc_map_pkg::RAM_WORDS];
    string               test_name;
    int                  cycle = 0;
    logic                fetch_busy = 1'b0;
    logic                lsu_busy = 1'b0;

    mem_subsys dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_req  (fetch_req),
        .fetch_resp (fetch_resp),
        .lsu_req    (lsu_req),
        .lsu_resp   (lsu_resp)
    );

    initial begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("Error: test %s, %s: expected %h, actual %h",
                     test_name, what, expected, actual);
            $display("Finished with errors");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic axi_lite_pkg::addr_t ram_addr(input int idx);
        return soc_map_pkg::RAM_BASE + 32'(idx * 4);
    endfunction

    function automatic logic in_ram(input axi_lite_pkg::addr_t addr);
        return addr >= soc_map_pkg::RAM_BASE &&
               addr < soc_map_pkg::RAM_BASE + 32'(soc_map_pkg::RAM_WORDS * 4);
    endfunction

    // fill pattern mixes every address bit
    function automatic axi_lite_pkg::data_t fill_word(input axi_lite_pkg::addr_t addr);
        return (addr * 32'h9E37_79B1) ^ 32'h3C5A_A5C3;
    endfunction

    // either just above the ram or in the low 16 MiB below the timer
    function automatic axi_lite_pkg::addr_t unmapped_addr(input logic [31:0] rnd);
        if (rnd[31]) begin
            return soc_map_pkg::RAM_BASE + 32'(soc_map_pkg::RAM_WORDS * 4) +
                   {16'h0, rnd[15:2], 2'b00};
        end
        return {8'h00, rnd[23:2], 2'b00};
    endfunction

    // byte lanes with a strobe take the new data
    function automatic axi_lite_pkg::data_t merge_bytes(input axi_lite_pkg::data_t old,
                                                        input axi_lite_pkg::data_t wdata,
                                                        input axi_lite_pkg::strb_t strb);
        axi_lite_pkg::data_t res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        return res;
    endfunction

    task automatic set_resp_ready(input int ch, input logic rdy);
        case (ch)
            CH_FETCH_R: fetch_req.r_ready <= rdy;
            CH_LSU_R:   lsu_req.r_ready <= rdy;
            default:    lsu_req.b_ready <= rdy;
        endcase
    endtask

    task automatic sample_resp(input int ch, output logic vld, output axi_lite_pkg::data_t data,
                               output axi_lite_pkg::resp_t resp);
        case (ch)
            CH_FETCH_R: begin
                vld  = fetch_resp.r_valid;
                data = fetch_resp.r.data;
                resp = fetch_resp.r.resp;
            end
            CH_LSU_R: begin
                vld  = lsu_resp.r_valid;
                data = lsu_resp.r.data;
                resp = lsu_resp.r.resp;
            end
            default: begin
                vld  = lsu_resp.b_valid;
                data = '0;
                resp = lsu_resp.b.resp;
            end
        endcase
    endtask

    // starts and ends on a rising edge and the last edge is the handshake
    task automatic wait_response(input int ch, input logic stall,
                                 output axi_lite_pkg::data_t data,
                                 output axi_lite_pkg::resp_t resp, output int hs_cycle);
        logic                rdy;
        logic                vld;
        logic                seen;
        logic                done;
        axi_lite_pkg::data_t d;
        axi_lite_pkg::resp_t r;
        seen     = 1'b0;
        done     = 1'b0;
        data     = '0;
        resp     = '0;
        hs_cycle = 0;
        while (!done) begin
            rdy = stall ? 1'($urandom_range(0, 1)) : 1'b1;
            set_resp_ready(ch, rdy);
            @(negedge clk);
            sample_resp(ch, vld, d, r);
            if (seen) begin
                // valid and payload must hold until accepted
                check_value("resp_valid_held", 1'b1, vld);
                check_value("resp_data_held", data, d);
                check_value("resp_code_held", resp, r);
            end
            if (vld) begin
                seen     = 1'b1;
                data     = d;
                resp     = r;
                done     = rdy;
                hs_cycle = cycle;
            end
            @(posedge clk);
        end
        set_resp_ready(ch, 1'b0);
    endtask

    task automatic fetch_read(input axi_lite_pkg::addr_t addr, output axi_lite_pkg::data_t data,
                              output axi_lite_pkg::resp_t resp, output int ar_cycle);
        int r_cycle;
        @(posedge clk);
        fetch_req.ar.addr  <= addr;
        fetch_req.ar_valid <= 1'b1;
        do @(negedge clk); while (!fetch_resp.ar_ready);
        ar_cycle = cycle;
        @(posedge clk);
        fetch_req.ar_valid <= 1'b0;
        fetch_busy = 1'b1;
        wait_response(CH_FETCH_R, 1'b1, data, resp, r_cycle);
        fetch_busy = 1'b0;
    endtask

    task automatic lsu_read(input axi_lite_pkg::addr_t addr, input logic stall,
                            output axi_lite_pkg::data_t data, output axi_lite_pkg::resp_t resp,
                            output int ar_cycle, output int r_cycle);
        @(posedge clk);
        lsu_req.ar.addr  <= addr;
        lsu_req.ar_valid <= 1'b1;
        do @(negedge clk); while (!lsu_resp.ar_ready);
        ar_cycle = cycle;
        @(posedge clk);
        lsu_req.ar_valid <= 1'b0;
        lsu_busy = 1'b1;
        wait_response(CH_LSU_R, stall, data, resp, r_cycle);
        lsu_busy = 1'b0;
    endtask

    task automatic lsu_write(input axi_lite_pkg::addr_t addr, input axi_lite_pkg::data_t data,
                             input axi_lite_pkg::strb_t strb, input logic stall,
                             output axi_lite_pkg::resp_t resp, output int b_cycle);
        axi_lite_pkg::data_t b_data;
        int                  idx;
        @(posedge clk);
        lsu_req.aw.addr  <= addr;
        lsu_req.w.data   <= data;
        lsu_req.w.strb   <= strb;
        lsu_req.aw_valid <= 1'b1;
        lsu_req.w_valid  <= 1'b1;
        do @(negedge clk); while (!lsu_resp.aw_ready);
        check_value("w_ready_with_aw", 1'b1, lsu_resp.w_ready);
        @(posedge clk);
        lsu_req.aw_valid <= 1'b0;
        lsu_req.w_valid  <= 1'b0;
        lsu_busy = 1'b1;
        wait_response(CH_LSU_B, stall, b_data, resp, b_cycle);
        lsu_busy = 1'b0;
        // model follows the ram on each write response
        if (resp == axi_lite_pkg::RESP_OKAY && in_ram(addr)) begin
            idx        = int'((addr - soc_map_pkg::RAM_BASE) >> 2);
            model[idx] = merge_bytes(model[idx], data, strb);
        end
    endtask

    task automatic fetch_traffic(input int count);
        axi_lite_pkg::data_t data;
        axi_lite_pkg::resp_t resp;
        int                  idx;
        int                  ar_cycle;
        repeat (count) begin
            idx = $urandom_range(0, soc_map_pkg::RAM_WORDS - 1);
            fetch_read(ram_addr(idx), data, resp, ar_cycle);
            check_value("fetch_rresp", axi_lite_pkg::RESP_OKAY, resp);
            check_value("fetch_rdata", model[idx], data);
            repeat ($urandom_range(0, 2)) @(posedge clk);
        end
    endtask

    task automatic lsu_traffic(input int count);
        axi_lite_pkg::addr_t addr;
        axi_lite_pkg::data_t wdata;
        axi_lite_pkg::data_t rdata;
        axi_lite_pkg::strb_t strb;
        axi_lite_pkg::resp_t resp;
        int                  idx;
        int                  c0;
        int                  c1;
        repeat (count) begin
            idx = $urandom_range(0, soc_map_pkg::RAM_WORDS - 1);
            case ($urandom_range(0, 5))
                0, 1: begin
                    // partial write, then read the merged word back
                    wdata = $urandom;
                    strb  = 4'($urandom);
                    lsu_write(ram_addr(idx), wdata, strb, 1'b1, resp, c0);
                    check_value("ram_bresp", axi_lite_pkg::RESP_OKAY, resp);
                    lsu_read(ram_addr(idx), 1'b1, rdata, resp, c0, c1);
                    check_value("ram_readback_rresp", axi_lite_pkg::RESP_OKAY, resp);
                    check_value("ram_readback", model[idx], rdata);
                end
                2: begin
                    lsu_read(ram_addr(idx), 1'b1, rdata, resp, c0, c1);
                    check_value("ram_rresp", axi_lite_pkg::RESP_OKAY, resp);
                    check_value("ram_rdata", model[idx], rdata);
                end
                3: begin
                    addr = soc_map_pkg::TIMER_BASE + 32'($urandom_range(0, 3) * 4);
                    lsu_read(addr, 1'b1, rdata, resp, c0, c1);
                    check_value("timer_rresp", axi_lite_pkg::RESP_OKAY, resp);
                    if (addr[3:0] >= 4'h8) begin
                        check_value("timer_spare_rdata", '0, rdata);
                    end
                end
                4: begin
                    lsu_read(unmapped_addr($urandom), 1'b1, rdata, resp, c0, c1);
                    check_value("unmapped_rresp", axi_lite_pkg::RESP_DECERR, resp);
                    check_value("unmapped_rdata", '0, rdata);
                end
                default: begin
                    lsu_write(unmapped_addr($urandom), $urandom, 4'hF, 1'b1, resp, c0);
                    check_value("unmapped_bresp", axi_lite_pkg::RESP_DECERR, resp);
                end
            endcase
            // idle gaps give the fetch master a turn
            repeat ($urandom_range(0, 4)) @(posedge clk);
        end
    endtask

    // a response reaches only a master that has a request in flight
    always @(negedge clk) begin
        if (rst_n) begin
            check_value("fetch_resp_owner", 1'b0, fetch_resp.r_valid && !fetch_busy);
            check_value("lsu_resp_owner", 1'b0,
                        (lsu_resp.r_valid || lsu_resp.b_valid) && !lsu_busy);
        end
    end

    initial begin
        repeat (RESET_CYCLES + TOTAL_TXN * TXN_CYCLES) @(posedge clk);
        $display("Timeout: the watchdog expired before all transactions completed");
        $display("Finished with errors");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        axi_lite_pkg::data_t fdata;
        axi_lite_pkg::data_t ldata;
        axi_lite_pkg::resp_t fresp;
        axi_lite_pkg::resp_t lresp;
        axi_lite_pkg::data_t v;
        int                  idx_a;
        int                  idx_b;
        int                  fetch_ar;
        int                  lsu_ar;
        int                  b_cyc;
        int                  r_cyc;
        void'($urandom(SEED));
        test_name = "reset";
        rst_n     <= 1'b0;
        fetch_req <= '0;
        lsu_req   <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        test_name = "ram_init";
        for (int i = 0; i < soc_map_pkg::RAM_WORDS; i++) begin
            lsu_write(ram_addr(i), fill_word(ram_addr(i)), 4'hF, 1'b1, lresp, b_cyc);
            check_value("init_bresp", axi_lite_pkg::RESP_OKAY, lresp);
        end

        // both masters raise valid on the same idle edge
        test_name = "arbitration";
        idx_a = $urandom_range(0, soc_map_pkg::RAM_WORDS - 1);
        idx_b = $urandom_range(0, soc_map_pkg::RAM_WORDS - 1);
        fork
            fetch_read(ram_addr(idx_a), fdata, fresp, fetch_ar);
            lsu_read(ram_addr(idx_b), 1'b1, ldata, lresp, lsu_ar, r_cyc);
        join
        check_value("lsu_addr_first", 1'b1, lsu_ar < fetch_ar);
        check_value("fetch_rresp", axi_lite_pkg::RESP_OKAY, fresp);
        check_value("fetch_rdata", model[idx_a], fdata);
        check_value("lsu_rresp", axi_lite_pkg::RESP_OKAY, lresp);
        check_value("lsu_rdata", model[idx_b], ldata);

        test_name = "timer";
        v = $urandom & 32'h7FFF_FFFF;
        lsu_write(soc_map_pkg::TIMER_BASE + 32'(soc_map_pkg::MTIME_HI_OFF), '0, 4'hF, 1'b1,
                  lresp, b_cyc);
        check_value("mtime_hi_bresp", axi_lite_pkg::RESP_OKAY, lresp);
        // b_ready high at once so the b handshake follows the write directly
        lsu_write(soc_map_pkg::TIMER_BASE + 32'(soc_map_pkg::MTIME_LO_OFF), v, 4'hF, 1'b0,
                  lresp, b_cyc);
        check_value("mtime_lo_bresp", axi_lite_pkg::RESP_OKAY, lresp);
        lsu_read(soc_map_pkg::TIMER_BASE + 32'(soc_map_pkg::MTIME_LO_OFF), 1'b1, ldata, lresp,
                 lsu_ar, r_cyc);
        check_value("mtime_lo_rresp", axi_lite_pkg::RESP_OKAY, lresp);
        check_value("mtime_lo_above_v", 1'b1, ldata > v);
        check_value("mtime_lo_bound", 1'b1, ldata <= v + 32'(r_cyc - b_cyc));

        test_name = "random_traffic";
        fork
            fetch_traffic(N_FETCH);
            lsu_traffic(N_LSU);
        join

        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== soc_map_pkg.sv ====
package soc_map_pkg;

    // word ram, 1 KiB
    localparam logic [31:0] RAM_BASE  = 32'h8000_0000;
    localparam int          RAM_WORDS = 256;

    // machine timer
    localparam logic [31:0] TIMER_BASE = 32'h0200_0000;
    localparam int          TIMER_SPAN = 16;

    localparam logic [3:0] MTIME_LO_OFF = 4'h0;
    localparam logic [3:0] MTIME_HI_OFF = 4'h4;

    typedef enum logic {
        MASTER_FETCH,
        MASTER_LSU
    } master_t;

    typedef enum logic [1:0] {
        SLV_RAM,
        SLV_TIMER,
        SLV_NONE
    } slave_t;

endpackage

// ==== xbar.sv ====
module xbar (
    input  logic                       clk,
    input  logic                       rst_n,
    input  axi_lite_pkg::req_t         bus_req,
    output axi_lite_pkg::resp_t_bundle bus_resp,
    output axi_lite_pkg::req_t         ram_req,
    input  axi_lite_pkg::resp_t_bundle ram_resp,
    output axi_lite_pkg::req_t         timer_req,
    input  axi_lite_pkg::resp_t_bundle timer_resp
);

    soc_map_pkg::slave_t dec_sel;
    soc_map_pkg::slave_t sel_q;
    soc_map_pkg::slave_t sel;
    axi_lite_pkg::addr_t dec_addr;
    logic pending;
    logic err_r_valid_q;
    logic err_b_valid_q;
    logic err_wr_ready;
    logic addr_hs;
    logic resp_hs;

    function automatic soc_map_pkg::slave_t decode(input axi_lite_pkg::addr_t addr);
        if (addr >= soc_map_pkg::RAM_BASE &&
            addr < soc_map_pkg::RAM_BASE + 32'(soc_map_pkg::RAM_WORDS * 4)) begin
            return soc_map_pkg::SLV_RAM;
        end
        if (addr >= soc_map_pkg::TIMER_BASE &&
            addr < soc_map_pkg::TIMER_BASE + 32'(soc_map_pkg::TIMER_SPAN)) begin
            return soc_map_pkg::SLV_TIMER;
        end
        return soc_map_pkg::SLV_NONE;
    endfunction

    // reads win when both address channels are valid
    assign dec_addr = bus_req.ar_valid ? bus_req.ar.addr : bus_req.aw.addr;
    assign dec_sel  = decode(dec_addr);
    assign sel      = pending ? sel_q : dec_sel;

    always_comb begin
        ram_req            = bus_req;
        ram_req.ar_valid   = bus_req.ar_valid && (sel == soc_map_pkg::SLV_RAM);
        ram_req.aw_valid   = bus_req.aw_valid && (sel == soc_map_pkg::SLV_RAM);
        ram_req.w_valid    = bus_req.w_valid && (sel == soc_map_pkg::SLV_RAM);
        ram_req.r_ready    = bus_req.r_ready && (sel == soc_map_pkg::SLV_RAM);
        ram_req.b_ready    = bus_req.b_ready && (sel == soc_map_pkg::SLV_RAM);
        timer_req          = bus_req;
        timer_req.ar_valid = bus_req.ar_valid && (sel == soc_map_pkg::SLV_TIMER);
        timer_req.aw_valid = bus_req.aw_valid && (sel == soc_map_pkg::SLV_TIMER);
        timer_req.w_valid  = bus_req.w_valid && (sel == soc_map_pkg::SLV_TIMER);
        timer_req.r_ready  = bus_req.r_ready && (sel == soc_map_pkg::SLV_TIMER);
        timer_req.b_ready  = bus_req.b_ready && (sel == soc_map_pkg::SLV_TIMER);
    end

    assign err_wr_ready = !pending && bus_req.aw_valid && bus_req.w_valid &&
                          !bus_req.ar_valid;

    always_comb begin
        case (sel)
            soc_map_pkg::SLV_RAM:   bus_resp = ram_resp;
            soc_map_pkg::SLV_TIMER: bus_resp = timer_resp;
            default: begin
                // unmapped addresses get an answer here with zero data
                bus_resp          = '0;
                bus_resp.ar_ready = !pending;
                bus_resp.aw_ready = err_wr_ready;
                bus_resp.w_ready  = err_wr_ready;
                bus_resp.r.resp   = axi_lite_pkg::RESP_DECERR;
                bus_resp.r_valid  = err_r_valid_q;
                bus_resp.b.resp   = axi_lite_pkg::RESP_DECERR;
                bus_resp.b_valid  = err_b_valid_q;
            end
        endcase
    end

    assign addr_hs = (bus_req.ar_valid && bus_resp.ar_ready) ||
                     (bus_req.aw_valid && bus_resp.aw_ready);
    assign resp_hs = (bus_resp.r_valid && bus_req.r_ready) ||
                     (bus_resp.b_valid && bus_req.b_ready);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending       <= 1'b0;
            sel_q         <= soc_map_pkg::SLV_NONE;
            err_r_valid_q <= 1'b0;
            err_b_valid_q <= 1'b0;
        end else begin
            if (addr_hs) begin
                pending <= 1'b1;
                sel_q   <= dec_sel;
            end else if (resp_hs) begin
                pending <= 1'b0;
            end
            if (addr_hs && dec_sel == soc_map_pkg::SLV_NONE) begin
                err_r_valid_q <= bus_req.ar_valid;
                err_b_valid_q <= !bus_req.ar_valid;
            end else if (resp_hs) begin
                err_r_valid_q <= 1'b0;
                err_b_valid_q <= 1'b0;
            end
        end
    end

    // only the target of the open transaction may hold a response
    a_one_slave: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({ram_resp.r_valid || ram_resp.b_valid,
                  timer_resp.r_valid || timer_resp.b_valid,
                  err_r_valid_q || err_b_valid_q}));

    // upstream must hold off new addresses until the response is done
    a_no_addr_pending: assert property (@(posedge clk) disable iff (!rst_n)
        pending |-> !(bus_req.ar_valid || bus_req.aw_valid));

endmodule
